// ==== logic/zipdbg_macros.svh ====
`ifndef ZIPDBG_MACROS_SVH
`define ZIPDBG_MACROS_SVH

// Debug bus addressing
// Byte address width of the AXI-lite debug port
`define ZIPDBG_ADDR_WIDTH 8

// Power-on behavior
// Cycles the CPU reset is held after bus or CPU reset
`define ZIPDBG_RESET_DURATION 10
// Halt request value coming out of reset, also the catch default
`define ZIPDBG_START_HALTED 1'b1

// Control word bit positions
// All of them sit in byte lane 0
// Halt request, set to stop and clear to run
`define ZIPDBG_HALT_BIT 0
// Single step, reads back as zero
`define ZIPDBG_STEP_BIT 2
// CPU reset request
`define ZIPDBG_RESET_BIT 3
// Cache clear, only taken together with halt
`define ZIPDBG_CLEAR_BIT 4
// Halt on fault rather than reset
`define ZIPDBG_CATCH_BIT 5

`endif

// ==== logic/zipdbg_axil_pkg.sv ====
`include "zipdbg_macros.svh"

package zipdbg_axil_pkg;

	// Byte address as seen on the bus
	typedef logic [`ZIPDBG_ADDR_WIDTH-1:0] dbg_addr_t;
	// Word index, byte lanes dropped
	// Top bit set selects the CPU register space
	typedef logic [`ZIPDBG_ADDR_WIDTH-3:0] dbg_word_addr_t;
	// Debug bus is always 32 bits wide
	typedef logic [31:0] dbg_data_t;
	typedef logic [3:0] dbg_strb_t;

	// Master side of the debug bus
	typedef struct packed {
		// Write address channel
		logic      awvalid;
		dbg_addr_t awaddr;
		// Write data channel
		logic      wvalid;
		dbg_data_t wdata;
		dbg_strb_t wstrb;
		// Write response channel
		logic      bready;
		// Read address channel
		logic      arvalid;
		dbg_addr_t araddr;
		// Read data channel
		logic      rready;
	} dbg_axil_req_t;

	// Slave side of the debug bus
	// Responses are always OKAY, so no resp fields
	typedef struct packed {
		logic      awready;
		logic      wready;
		logic      bvalid;
		logic      arready;
		logic      rvalid;
		dbg_data_t rdata;
	} dbg_axil_rsp_t;

endpackage

// ==== logic/zipdbg_cpu_pkg.sv ====
package zipdbg_cpu_pkg;

	// CPU register index, 32 registers
	typedef logic [4:0] cpu_reg_t;

	// Everything driven into the CPU debug port
	typedef struct packed {
		// Control block commands
		logic                       halt;
		logic                       reset;
		logic                       step;
		logic                       clear_cache;
		// Register write, held while the CPU stalls
		logic                       we;
		cpu_reg_t                   wreg;
		zipdbg_axil_pkg::dbg_data_t wdata;
		// Register read index, data returns a cycle later
		cpu_reg_t                   rreg;
	} cpu_dbg_cmd_t;

	// What the CPU returns
	typedef struct packed {
		// Low once the CPU has come to a full stop
		logic                       stall;
		// Fault or break instruction
		logic                       brk;
		logic [2:0]                 cc;
		zipdbg_axil_pkg::dbg_data_t rdata;
	} cpu_dbg_rsp_t;

	// Control space write from the bus slave
	// Single-cycle strobe, never back-pressured
	typedef struct packed {
		logic                       strobe;
		zipdbg_axil_pkg::dbg_data_t data;
		zipdbg_axil_pkg::dbg_strb_t strb;
	} ctrl_write_t;

	// Status word read back from the control space
	typedef struct packed {
		logic [19:0] zero_hi;
		logic        brk;
		logic        interrupt;
		logic [1:0]  cc;
		logic [1:0]  zero_mid;
		logic        catch_en;
		// Clear cache is not reported
		logic        zero_clr;
		logic        reset;
		// Step is write only
		logic        zero_step;
		// Inverse of the CPU stall
		logic        halted;
		logic        halt_req;
	} dbg_status_t;

endpackage

// ==== logic/zipdbg_skid.sv ====
`timescale 1ns/100ps

module zipdbg_skid #(
	parameter int WIDTH = 8
) (
	input  logic             S_AXI_ACLK,
	input  logic             S_AXI_ARESETN,
	// Upstream side
	input  logic             i_valid,
	output logic             o_ready,
	input  logic [WIDTH-1:0] i_data,
	// Downstream side
	output logic             o_valid,
	input  logic             i_ready,
	output logic [WIDTH-1:0] o_data
);

	// One word of holding space
	logic             full;
	logic [WIDTH-1:0] hold_data;

	// Fill when a word arrives that downstream can't take
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			full <= 1'b0;
		else if (i_ready)
			full <= 1'b0;
		else if (i_valid && o_ready)
			full <= 1'b1;
	end

	// Capture whatever is on the input while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			hold_data <= i_data;
	end

	assign o_ready = !full;

	// Straight through while empty
	assign o_valid = full || i_valid;
	assign o_data  = full ? hold_data : i_data;

endmodule

// ==== logic/zipdbg_axil_slave.sv ====
`timescale 1ns/100ps
`include "zipdbg_macros.svh"

module zipdbg_axil_slave (
	input  logic                           S_AXI_ACLK,
	input  logic                           S_AXI_ARESETN,
	// AXI-lite debug port
	input  zipdbg_axil_pkg::dbg_axil_req_t i_axil,
	output zipdbg_axil_pkg::dbg_axil_rsp_t o_axil,
	// Control block side
	output zipdbg_cpu_pkg::ctrl_write_t    o_ctrl_write,
	output logic                           o_cpu_write_any,
	// CPU register access
	output logic                           o_cpu_write_valid,
	output zipdbg_cpu_pkg::cpu_reg_t       o_cpu_wreg,
	output zipdbg_axil_pkg::dbg_data_t     o_cpu_wdata,
	output zipdbg_cpu_pkg::cpu_reg_t       o_cpu_rreg,
	input  logic                           i_cpu_stall,
	input  zipdbg_axil_pkg::dbg_data_t     i_cpu_rdata,
	input  zipdbg_cpu_pkg::dbg_status_t    i_status
);

	import zipdbg_axil_pkg::*;

	localparam int SPACE_BIT = $bits(dbg_word_addr_t) - 1;

	// Skid outputs
	logic                  aw_valid, w_valid, ar_valid;
	logic                  aw_ready, w_ready, ar_ready;
	dbg_word_addr_t        aw_addr, ar_addr;
	logic [$bits(dbg_strb_t)+$bits(dbg_data_t)-1:0] w_skid_data;
	dbg_strb_t             w_strb;
	dbg_data_t             w_data;
	// Sequencing
	logic                  write_ready, read_ready;
	logic                  aw_cpu_space, ar_cpu_space;
	logic                  write_stall, cpu_write_now;
	logic                  cpu_read_pending;
	logic                  bvalid, rvalid;
	dbg_data_t             rdata;

	//////////////////////////////////////////////////////////////
	// Channel skid buffers
	//////////////////////////////////////////////////////////////

	// Byte lanes dropped on both address channels
	zipdbg_skid #(.WIDTH($bits(dbg_word_addr_t))) aw_skid (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_axil.awvalid),
		.o_ready      (aw_ready),
		.i_data       (i_axil.awaddr[`ZIPDBG_ADDR_WIDTH-1:2]),
		.o_valid      (aw_valid),
		.i_ready      (write_ready),
		.o_data       (aw_addr)
	);

	// Strobe travels with the data
	zipdbg_skid #(.WIDTH($bits(dbg_strb_t) + $bits(dbg_data_t))) w_skid (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_axil.wvalid),
		.o_ready      (w_ready),
		.i_data       ({i_axil.wstrb, i_axil.wdata}),
		.o_valid      (w_valid),
		.i_ready      (write_ready),
		.o_data       (w_skid_data)
	);

	zipdbg_skid #(.WIDTH($bits(dbg_word_addr_t))) ar_skid (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_axil.arvalid),
		.o_ready      (ar_ready),
		.i_data       (i_axil.araddr[`ZIPDBG_ADDR_WIDTH-1:2]),
		.o_valid      (ar_valid),
		.i_ready      (read_ready),
		.o_data       (ar_addr)
	);

	assign w_strb = w_skid_data[$bits(w_skid_data)-1 -: $bits(dbg_strb_t)];
	assign w_data = w_skid_data[$bits(dbg_data_t)-1:0];

	// Space decode
	assign aw_cpu_space = aw_addr[SPACE_BIT];
	assign ar_cpu_space = ar_addr[SPACE_BIT];

	//////////////////////////////////////////////////////////////
	// Write sequencing
	//////////////////////////////////////////////////////////////

	// CPU write still waiting on the CPU to stop
	assign write_stall = o_cpu_write_valid && i_cpu_stall;

	// Both halves present, B slot free
	// Control writes never wait on the CPU
	assign write_ready = aw_valid && w_valid
		&& (!bvalid || i_axil.bready)
		&& (!aw_cpu_space || !write_stall);

	// Register write with at least one lane enabled
	assign cpu_write_now   = write_ready && aw_cpu_space && (|w_strb);
	assign o_cpu_write_any = cpu_write_now;

	// Held against the stall, consumed once it drops
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_cpu_write_valid <= 1'b0;
		else if (!write_stall)
			o_cpu_write_valid <= cpu_write_now;
	end

	// Register index and value, frozen while stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			o_cpu_wreg  <= aw_addr[4:0];
			o_cpu_wdata <= w_data;
		end
	end

	// Response a cycle after acceptance
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			bvalid <= 1'b0;
		else if (write_ready)
			bvalid <= 1'b1;
		else if (i_axil.bready)
			bvalid <= 1'b0;
	end

	// Control write strobe in the acceptance cycle
	assign o_ctrl_write = '{
		strobe: write_ready && !aw_cpu_space,
		data:   w_data,
		strb:   w_strb
	};

	//////////////////////////////////////////////////////////////
	// Read sequencing
	//////////////////////////////////////////////////////////////

	// One read in flight, R slot free
	assign read_ready = ar_valid && !cpu_read_pending
		&& (!rvalid || i_axil.rready);

	// CPU registers its data from this index
	assign o_cpu_rreg = ar_addr[4:0];

	// CPU data lands one cycle after acceptance
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cpu_read_pending <= 1'b0;
		else
			cpu_read_pending <= read_ready && ar_cpu_space;
	end

	// Control reads answer after one cycle, CPU reads after two
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rvalid <= 1'b0;
		else if (!rvalid || i_axil.rready)
			rvalid <= (read_ready && !ar_cpu_space) || cpu_read_pending;
	end

	// Read data select, held under back-pressure
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!rvalid || i_axil.rready)
		begin
			if (cpu_read_pending)
				rdata <= i_cpu_rdata;
			else
				rdata <= i_status;
		end
	end

	assign o_axil = '{
		awready: aw_ready,
		wready:  w_ready,
		bvalid:  bvalid,
		arready: ar_ready,
		rvalid:  rvalid,
		rdata:   rdata
	};

endmodule

// ==== logic/zipdbg_ctrl_regs.sv ====
`timescale 1ns/100ps
`include "zipdbg_macros.svh"

module zipdbg_ctrl_regs (
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	// Control space write from the slave
	input  zipdbg_cpu_pkg::ctrl_write_t i_ctrl_write,
	// CPU register write state
	input  logic                        i_cpu_write_valid,
	input  logic                        i_cpu_write_any,
	// External events
	input  logic                        i_cpu_reset,
	input  logic                        i_interrupt,
	input  zipdbg_cpu_pkg::cpu_dbg_rsp_t i_cpu,
	// Commands to the CPU
	output logic                        o_halt,
	output logic                        o_reset,
	output logic                        o_step,
	output logic                        o_clear_cache,
	output zipdbg_cpu_pkg::dbg_status_t o_status
);

	localparam int HOLD_W = $clog2(`ZIPDBG_RESET_DURATION + 1);

	// Decoded requests, one cycle wide
	logic              reset_request;
	logic              release_request;
	logic              halt_request;
	logic              step_request;
	logic              clear_request;
	// Power-on hold
	logic [HOLD_W-1:0] hold_count;
	logic              hold_active;
	// Halt on fault instead of reset
	logic              catch_en;

	//////////////////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////////////////

	// Each bit only counts with its byte lane enabled
	assign reset_request = i_ctrl_write.strobe
		&& i_ctrl_write.strb[`ZIPDBG_RESET_BIT/8]
		&& i_ctrl_write.data[`ZIPDBG_RESET_BIT];
	assign release_request = i_ctrl_write.strobe
		&& i_ctrl_write.strb[`ZIPDBG_HALT_BIT/8]
		&& !i_ctrl_write.data[`ZIPDBG_HALT_BIT];
	assign halt_request = i_ctrl_write.strobe
		&& i_ctrl_write.strb[`ZIPDBG_HALT_BIT/8]
		&& i_ctrl_write.data[`ZIPDBG_HALT_BIT];
	assign step_request = i_ctrl_write.strobe
		&& i_ctrl_write.strb[`ZIPDBG_STEP_BIT/8]
		&& i_ctrl_write.data[`ZIPDBG_STEP_BIT];
	assign clear_request = i_ctrl_write.strobe
		&& i_ctrl_write.strb[`ZIPDBG_CLEAR_BIT/8]
		&& i_ctrl_write.data[`ZIPDBG_CLEAR_BIT];

	//////////////////////////////////////////////////////////////
	// Reset and halt
	//////////////////////////////////////////////////////////////

	// Hold counter, restarted by either reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			hold_count <= HOLD_W'(`ZIPDBG_RESET_DURATION);
		else if (hold_active)
			hold_count <= hold_count - 1'b1;
	end

	assign hold_active = (hold_count != '0);

	// CPU reset
	// Unhandled break resets when nobody catches it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_reset <= 1'b1;
		else if (hold_active)
			o_reset <= 1'b1;
		else if (i_cpu.brk && !catch_en)
			o_reset <= 1'b1;
		else
			o_reset <= reset_request;
	end

	// Halt request, later conditions win
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_halt <= `ZIPDBG_START_HALTED;
		else
		begin
			// Release only from a full stop with no write in flight
			if (!i_cpu_write_valid && !i_cpu.stall
					&& (release_request || step_request))
				o_halt <= 1'b0;
			// Caught fault
			if (i_cpu.brk && catch_en)
				o_halt <= 1'b1;
			// Halt bit, unless stepping
			if (halt_request && !step_request)
				o_halt <= 1'b1;
			// Register writes need a stopped CPU
			if (i_cpu_write_any)
				o_halt <= 1'b1;
			// Stop again after the step
			if (o_step)
				o_halt <= 1'b1;
			if (o_clear_cache || clear_request)
				o_halt <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////
	// Step, clear and catch
	//////////////////////////////////////////////////////////////

	// Step stays up until the CPU stops again
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_step <= 1'b0;
		else if (step_request)
			o_step <= 1'b1;
		else if (!i_cpu.stall)
			o_step <= 1'b0;
	end

	// Clear and halt bits written together
	// Drops once the CPU is stopped under halt
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_reset)
			o_clear_cache <= 1'b0;
		else if (clear_request && halt_request)
			o_clear_cache <= 1'b1;
		else if (o_halt && !i_cpu.stall)
			o_clear_cache <= 1'b0;
	end

	// Catch follows its bit on any enabled write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			catch_en <= `ZIPDBG_START_HALTED;
		else if (i_ctrl_write.strobe && i_ctrl_write.strb[`ZIPDBG_CATCH_BIT/8])
			catch_en <= i_ctrl_write.data[`ZIPDBG_CATCH_BIT];
	end

	// Status word
	// cc[2] isn't reported
	assign o_status = '{
		zero_hi:   '0,
		brk:       i_cpu.brk,
		interrupt: i_interrupt,
		cc:        i_cpu.cc[1:0],
		zero_mid:  '0,
		catch_en:  catch_en,
		zero_clr:  1'b0,
		reset:     o_reset,
		zero_step: 1'b0,
		halted:    !i_cpu.stall,
		halt_req:  o_halt
	};

endmodule

// ==== logic/zipdbg_top.sv ====
`timescale 1ns/100ps

module zipdbg_top (
	input  logic                           S_AXI_ACLK,
	input  logic                           S_AXI_ARESETN,
	// AXI-lite debug port
	input  zipdbg_axil_pkg::dbg_axil_req_t i_axil,
	output zipdbg_axil_pkg::dbg_axil_rsp_t o_axil,
	// CPU debug port
	output zipdbg_cpu_pkg::cpu_dbg_cmd_t   o_cpu,
	input  zipdbg_cpu_pkg::cpu_dbg_rsp_t   i_cpu,
	input  logic                           i_interrupt,
	input  logic                           i_cpu_reset
);

	import zipdbg_axil_pkg::*;
	import zipdbg_cpu_pkg::*;

	// Slave to control block
	ctrl_write_t ctrl_write;
	logic        cpu_write_valid;
	logic        cpu_write_any;
	dbg_status_t status;
	// CPU command fields
	logic        halt, reset, step, clear_cache;
	cpu_reg_t    wreg, rreg;
	dbg_data_t   wdata;

	zipdbg_axil_slave i_zipdbg_axil_slave (
		.S_AXI_ACLK       (S_AXI_ACLK),
		.S_AXI_ARESETN    (S_AXI_ARESETN),
		.i_axil           (i_axil),
		.o_axil           (o_axil),
		.o_ctrl_write     (ctrl_write),
		.o_cpu_write_any  (cpu_write_any),
		.o_cpu_write_valid(cpu_write_valid),
		.o_cpu_wreg       (wreg),
		.o_cpu_wdata      (wdata),
		.o_cpu_rreg       (rreg),
		.i_cpu_stall      (i_cpu.stall),
		.i_cpu_rdata      (i_cpu.rdata),
		.i_status         (status)
	);

	zipdbg_ctrl_regs i_zipdbg_ctrl_regs (
		.S_AXI_ACLK       (S_AXI_ACLK),
		.S_AXI_ARESETN    (S_AXI_ARESETN),
		.i_ctrl_write     (ctrl_write),
		.i_cpu_write_valid(cpu_write_valid),
		.i_cpu_write_any  (cpu_write_any),
		.i_cpu_reset      (i_cpu_reset),
		.i_interrupt      (i_interrupt),
		.i_cpu            (i_cpu),
		.o_halt           (halt),
		.o_reset          (reset),
		.o_step           (step),
		.o_clear_cache    (clear_cache),
		.o_status         (status)
	);

	// Gather the CPU command word
	assign o_cpu = '{
		halt:        halt,
		reset:       reset,
		step:        step,
		clear_cache: clear_cache,
		we:          cpu_write_valid,
		wreg:        wreg,
		wdata:       wdata,
		rreg:        rreg
	};

endmodule

// ==== verification/zipdbg_clkgen.sv ====
`timescale 1ns/100ps

module zipdbg_clkgen (
	output logic o_clk,
	output logic o_rst_n
);

	// 8 ns period
	initial
	begin
		o_clk = 1'b0;
		forever
			#4 o_clk = ~o_clk;
	end

	// Reset low for 16 edges, released just after an edge
	initial
	begin
		o_rst_n = 1'b0;
		repeat (16) @(posedge o_clk);
		#1 o_rst_n = 1'b1;
	end

endmodule

// ==== verification/zipdbg_tb.sv ====
`timescale 1ns/100ps
`include "zipdbg_macros.svh"

module zipdbg_tb;

	import zipdbg_axil_pkg::*;
	import zipdbg_cpu_pkg::*;

	localparam int N_HALT = 16;
	localparam int N_WR = 12;
	localparam int N_RD = 16;
	// Halt loop does a write and a read each pass, plus the fixed tests
	localparam int N_TRANS = 2 * N_HALT + N_WR + N_RD + 16;
	localparam int TIMEOUT_CYCLES = 400 * N_TRANS;

	logic           clk, rst_n;
	dbg_axil_req_t  axil;
	dbg_axil_rsp_t  axil_rsp;
	cpu_dbg_cmd_t   cpu_cmd;
	cpu_dbg_rsp_t   cpu_rsp;
	logic           interrupt, cpu_reset;
	// CPU model state
	logic           cpu_stall, cpu_brk;
	logic [2:0]     cpu_cc;
	dbg_data_t      cpu_rdata;
	dbg_data_t      cpu_regs [32];
	logic           stall_next;
	dbg_data_t      rdata_next;
	// Reference model
	dbg_data_t      exp_regs [32];
	logic           exp_halt, exp_catch;
	// Monitor counters
	cpu_dbg_cmd_t   we_log [$];
	int             step_pulses, halt_releases, clear_cycles;
	logic           prev_halt;
	int             cycle_count;

	zipdbg_clkgen i_zipdbg_clkgen (
		.o_clk  (clk),
		.o_rst_n(rst_n)
	);

	zipdbg_top i_zipdbg_top (
		.S_AXI_ACLK   (clk),
		.S_AXI_ARESETN(rst_n),
		.i_axil       (axil),
		.o_axil       (axil_rsp),
		.o_cpu        (cpu_cmd),
		.i_cpu        (cpu_rsp),
		.i_interrupt  (interrupt),
		.i_cpu_reset  (cpu_reset)
	);

	assign cpu_rsp = '{stall: cpu_stall, brk: cpu_brk, cc: cpu_cc, rdata: cpu_rdata};

	//////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////

	function automatic dbg_data_t fill_word(int idx);
		return 32'hc0de_0000 ^ (idx * 32'h0101_0101) ^ (idx << 27);
	endfunction

	// Status layout built bit by bit
	function automatic dbg_status_t status_word(logic halt, logic halted,
			logic catch_en, logic rst, logic brk);
		return {20'b0, brk, interrupt, cpu_cc[1:0], 2'b0, catch_en, 1'b0,
			rst, 1'b0, halted, halt};
	endfunction

	task automatic stop_on_error(string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_data(string name, dbg_data_t got, dbg_data_t exp);
		if (got !== exp)
			stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_status(dbg_status_t got, dbg_status_t exp);
		if (got !== exp)
			stop_on_error($sformatf("[FAIL] status got %h expected %h", got, exp));
	endtask

	// we, wreg and wdata only compared on a write
	task automatic check_cmd(cpu_dbg_cmd_t got, cpu_dbg_cmd_t exp);
		if ({got.halt, got.reset, got.step, got.clear_cache}
				!== {exp.halt, exp.reset, exp.step, exp.clear_cache})
			stop_on_error($sformatf("[FAIL] o_cpu halt/reset/step/clear got %h expected %h",
				{got.halt, got.reset, got.step, got.clear_cache},
				{exp.halt, exp.reset, exp.step, exp.clear_cache}));
		if (exp.we && {got.we, got.wreg, got.wdata} !== {exp.we, exp.wreg, exp.wdata})
			stop_on_error($sformatf("[FAIL] o_cpu we/wreg/wdata got %h expected %h",
				{got.we, got.wreg, got.wdata}, {exp.we, exp.wreg, exp.wdata}));
	endtask

	// Drive point is 1 ns after each rising edge
	task automatic idle(int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic expect_cmd(logic halt, logic rst, logic step, logic clr);
		cpu_dbg_cmd_t exp;
		exp = '0;
		exp.halt = halt;
		exp.reset = rst;
		exp.step = step;
		exp.clear_cache = clr;
		@(negedge clk);
		check_cmd(cpu_cmd, exp);
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(dbg_addr_t addr, dbg_data_t data, dbg_strb_t strb);
		int  aw_delay, w_delay;
		bit  aw_done, w_done, b_done;
		aw_delay = $urandom_range(0, 3);
		w_delay = $urandom_range(0, 3);
		aw_done = 0;
		w_done = 0;
		b_done = 0;
		axil.awaddr = addr;
		axil.wdata = data;
		axil.wstrb = strb;
		while (!(aw_done && w_done))
		begin
			axil.awvalid = !aw_done && (aw_delay == 0);
			axil.wvalid = !w_done && (w_delay == 0);
			if (aw_delay > 0)
				aw_delay--;
			if (w_delay > 0)
				w_delay--;
			@(negedge clk);
			if (axil.awvalid && axil_rsp.awready)
				aw_done = 1;
			if (axil.wvalid && axil_rsp.wready)
				w_done = 1;
			@(posedge clk);
			#1;
		end
		axil.awvalid = 1'b0;
		axil.wvalid = 1'b0;
		// B channel with random stalls
		while (!b_done)
		begin
			axil.bready = $urandom_range(0, 1);
			@(negedge clk);
			b_done = axil_rsp.bvalid && axil.bready;
			@(posedge clk);
			#1;
		end
		axil.bready = 1'b0;
	endtask

	task automatic bus_read(dbg_addr_t addr, output dbg_data_t data);
		int  ar_delay;
		bit  ar_done, r_done;
		ar_delay = $urandom_range(0, 3);
		ar_done = 0;
		r_done = 0;
		axil.araddr = addr;
		while (!r_done)
		begin
			axil.arvalid = !ar_done && (ar_delay == 0);
			axil.rready = $urandom_range(0, 1);
			if (ar_delay > 0)
				ar_delay--;
			@(negedge clk);
			if (axil.arvalid && axil_rsp.arready)
				ar_done = 1;
			if (axil_rsp.rvalid && axil.rready)
			begin
				r_done = 1;
				data = axil_rsp.rdata;
			end
			@(posedge clk);
			#1;
			if (ar_done)
				axil.arvalid = 1'b0;
		end
		axil.rready = 1'b0;
	endtask

	task automatic read_status(dbg_status_t exp);
		dbg_data_t got;
		bus_read(8'h00, got);
		check_status(got, exp);
	endtask

	//////////////////////////////////////////////////////////////
	// CPU model and monitors
	//////////////////////////////////////////////////////////////

	// Snapshot at the falling edge, applied after the rising edge
	always @(negedge clk)
	begin
		stall_next = !cpu_cmd.halt;
		rdata_next = cpu_regs[cpu_cmd.rreg];
		if (cpu_cmd.we && !cpu_stall)
		begin
			cpu_regs[cpu_cmd.wreg] = cpu_cmd.wdata;
			we_log.push_back(cpu_cmd);
		end
		if (cpu_cmd.step)
			step_pulses++;
		if (prev_halt && !cpu_cmd.halt)
			halt_releases++;
		prev_halt = cpu_cmd.halt;
		if (cpu_cmd.clear_cache)
			clear_cycles++;
	end

	always @(posedge clk)
	begin
		#1;
		cpu_stall = stall_next;
		cpu_rdata = rdata_next;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_on_error("Timeout, the run did not finish in time");
	end

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////

	initial
	begin
		int           hold_cycles, steps0, rel0, clr0, r;
		dbg_data_t    d, got;
		cpu_dbg_cmd_t exp_we;
		void'($urandom(32'h87ec));
		axil = '0;
		interrupt = 1'b1;
		cpu_reset = 1'b0;
		cpu_stall = 1'b1;
		cpu_brk = 1'b0;
		cpu_cc = 3'b110;
		cpu_rdata = '0;
		stall_next = 1'b1;
		rdata_next = '0;
		prev_halt = 1'b0;
		step_pulses = 0;
		halt_releases = 0;
		clear_cycles = 0;
		cycle_count = 0;
		for (int i = 0; i < 32; i++)
		begin
			cpu_regs[i] = fill_word(i);
			exp_regs[i] = fill_word(i);
		end
		exp_halt = `ZIPDBG_START_HALTED;
		exp_catch = `ZIPDBG_START_HALTED;

		// Hold covers the first edges out of reset
		wait (rst_n);
		@(posedge clk);
		hold_cycles = 0;
		forever
		begin
			@(negedge clk);
			if (!cpu_cmd.reset)
				break;
			hold_cycles++;
		end
		if (hold_cycles != `ZIPDBG_RESET_DURATION)
			stop_on_error("CPU reset hold did not last the expected number of cycles");
		@(posedge clk);
		#1;
		read_status(status_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));

		// Halt bit set and cleared at random
		for (int i = 0; i < N_HALT; i++)
		begin
			// Side inputs move under the status reads
			interrupt = $urandom_range(0, 1);
			cpu_cc = $urandom_range(0, 7);
			exp_halt = $urandom_range(0, 1);
			bus_write(8'h00, 32'h20 | exp_halt, 4'hf);
			idle(4);
			read_status(status_word(exp_halt, exp_halt, exp_catch, 1'b0, 1'b0));
		end

		// CPU register writes, each one halts the CPU
		for (int i = 0; i < N_WR; i++)
		begin
			r = $urandom_range(0, 31);
			d = $urandom;
			bus_write({1'b1, r[4:0], 2'b00}, d, $urandom_range(1, 15));
			exp_regs[r] = d;
			while (we_log.size() == 0)
				idle(1);
			idle(3);
			exp_we = '0;
			exp_we.halt = 1'b1;
			exp_we.we = 1'b1;
			exp_we.wreg = r[4:0];
			exp_we.wdata = d;
			check_cmd(we_log.pop_front(), exp_we);
			if (we_log.size() != 0)
				stop_on_error("A CPU register write gave more than one write cycle");
		end
		exp_halt = 1'b1;
		idle(2);
		read_status(status_word(1'b1, 1'b1, exp_catch, 1'b0, 1'b0));

		// CPU register reads against the model
		for (int i = 0; i < N_RD; i++)
		begin
			r = $urandom_range(0, 31);
			bus_read({1'b1, r[4:0], 2'b00}, got);
			check_data($sformatf("cpu reg %0d", r), got, exp_regs[r]);
		end
		read_status(status_word(1'b1, 1'b1, exp_catch, 1'b0, 1'b0));

		// Single step from halt
		steps0 = step_pulses;
		rel0 = halt_releases;
		bus_write(8'h00, 32'h24, 4'hf);
		idle(4);
		if (step_pulses != steps0 + 1 || halt_releases != rel0 + 1)
			stop_on_error("Step write did not give one step pulse and one halt release");
		expect_cmd(1'b1, 1'b0, 1'b0, 1'b0);

		// Clear cache together with halt
		clr0 = clear_cycles;
		bus_write(8'h00, 32'h31, 4'hf);
		idle(3);
		if (clear_cycles != clr0 + 1)
			stop_on_error("Clear cache did not pulse for one cycle while stopped");
		expect_cmd(1'b1, 1'b0, 1'b0, 1'b0);

		// Caught break halts a running CPU
		bus_write(8'h00, 32'h20, 4'hf);
		idle(4);
		expect_cmd(1'b0, 1'b0, 1'b0, 1'b0);
		cpu_brk = 1'b1;
		idle(4);
		read_status(status_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b1));
		cpu_brk = 1'b0;
		idle(2);

		// Catch off, break resets
		bus_write(8'h00, 32'h01, 4'hf);
		idle(3);
		cpu_brk = 1'b1;
		idle(2);
		expect_cmd(1'b1, 1'b1, 1'b0, 1'b0);
		read_status(status_word(1'b1, 1'b1, 1'b0, 1'b1, 1'b1));
		cpu_brk = 1'b0;
		idle(2);
		expect_cmd(1'b1, 1'b0, 1'b0, 1'b0);

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== zipdbg_top.f ====
+incdir+logic
logic/zipdbg_axil_pkg.sv
logic/zipdbg_cpu_pkg.sv
logic/zipdbg_skid.sv
logic/zipdbg_axil_slave.sv
logic/zipdbg_ctrl_regs.sv
logic/zipdbg_top.sv
verification/zipdbg_clkgen.sv
verification/zipdbg_tb.sv

// ==== Bender.yml ====
package:
  name: zipdbg

sources:
  - include_dirs:
      - logic
    files:
      - logic/zipdbg_axil_pkg.sv
      - logic/zipdbg_cpu_pkg.sv
      - logic/zipdbg_skid.sv
      - logic/zipdbg_axil_slave.sv
      - logic/zipdbg_ctrl_regs.sv
      - logic/zipdbg_top.sv
  - target: test
    files:
      - verification/zipdbg_clkgen.sv
      - verification/zipdbg_tb.sv
